//--- source/fft_num_pkg.sv
package fft_num_pkg;

    // Transform size and fixed-point formats
    localparam int fft_points    = 16;
    localparam int fft_stages    = $clog2(fft_points);
    localparam int addr_width    = $clog2(fft_points);
    localparam int sample_width  = 16;
    // Twiddles are Q1.15
    localparam int twiddle_width = 16;

    typedef logic signed [sample_width-1:0] sample_t;
    typedef logic [addr_width-2:0] twiddle_index_t;

endpackage

//--- source/fft_bus_pkg.sv
package fft_bus_pkg;

    // Sample and bin words carry the real part in bits 15..0 and
    // the imaginary part in bits 31..16
    localparam int wb_addr_width = 5;
    localparam int wb_data_width = 32;

    // Word addresses 0..15 are samples or bins, 16 is control and status
    localparam logic [wb_addr_width-1:0] reg_ctrl = 5'd16;

    localparam int status_busy_bit = 0;
    localparam int status_done_bit = 1;

endpackage

//--- source/sample_loader.sv
`timescale 1ns/10ps

module sample_loader #(
    parameter int points = fft_num_pkg::fft_points,
    parameter int stages = fft_num_pkg::fft_stages
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  in_cyc,
    input  logic                                  in_stb,
    input  logic                                  in_we,
    input  logic [fft_bus_pkg::wb_addr_width-1:0] in_adr,
    input  logic [fft_bus_pkg::wb_data_width-1:0] in_dat_w,
    input  logic                                  busy,
    output logic                                  in_ack,
    output logic [fft_bus_pkg::wb_data_width-1:0] in_dat_r,
    output logic                                  load_we,
    output logic [stages-1:0]                     load_addr,
    output logic [fft_bus_pkg::wb_data_width-1:0] load_data,
    output logic                                  start
);
    import fft_bus_pkg::*;

    logic              request;
    logic              write_sample;
    logic              write_start;
    logic [stages-1:0] rev_addr;

    // A new request is one that has not been acknowledged yet
    assign request      = in_cyc && in_stb && !in_ack;
    assign write_sample = request && in_we && (in_adr < points) && !busy;
    assign write_start  = request && in_we && (in_adr == reg_ctrl) && in_dat_w[0] && !busy;
    assign in_dat_r     = '0;

    // Samples land at bit-reversed positions so the engine can run DIT in place
    always_comb begin
        for (int i = 0; i < stages; i++) begin
            rev_addr[i] = in_adr[stages-1-i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            in_ack  <= 1'b0;
            load_we <= 1'b0;
            start   <= 1'b0;
        end else begin
            in_ack  <= request;
            load_we <= write_sample;
            start   <= write_start;
        end
    end

    always_ff @(posedge clk) begin
        load_addr <= rev_addr;
        load_data <= in_dat_w;
    end

    assert property (@(posedge clk) disable iff (rst) in_ack |=> !in_ack);
    assert property (@(posedge clk) disable iff (rst) !(load_we && busy));

endmodule

//--- source/twiddle_rom.sv
`timescale 1ns/10ps

module twiddle_rom #(
    parameter int points = fft_num_pkg::fft_points,
    parameter int stages = fft_num_pkg::fft_stages
) (
    input  logic [stages-2:0]                             index,
    output logic signed [fft_num_pkg::twiddle_width-1:0] w_re,
    output logic signed [fft_num_pkg::twiddle_width-1:0] w_im
);
    import fft_num_pkg::*;

    localparam real pi         = 3.14159265358979;
    localparam real full_scale = 2.0 ** (twiddle_width - 1);

    logic signed [twiddle_width-1:0] cos_table [points/2];
    logic signed [twiddle_width-1:0] sin_table [points/2];

    // Round to nearest, +1.0 clips to the largest positive code
    function automatic logic signed [twiddle_width-1:0] quantize(input real value);
        real scaled;
        scaled = $floor(value * full_scale + 0.5);
        if (scaled > full_scale - 1.0) begin
            scaled = full_scale - 1.0;
        end
        return twiddle_width'($rtoi(scaled));
    endfunction

    for (genvar k = 0; k < points/2; k++) begin : g_entry
        localparam real angle = 2.0 * pi * k / points;
        localparam logic signed [twiddle_width-1:0] cos_k = quantize($cos(angle));
        localparam logic signed [twiddle_width-1:0] sin_k = quantize(-$sin(angle));
        assign cos_table[k] = cos_k;
        assign sin_table[k] = sin_k;
    end

    assign w_re = cos_table[index];
    assign w_im = sin_table[index];

endmodule

//--- source/butterfly_unit.sv
`timescale 1ns/10ps

module butterfly_unit #(
    parameter int twiddle_width = fft_num_pkg::twiddle_width,
    parameter int tag_width     = 2 * fft_num_pkg::addr_width
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        in_valid,
    input  logic signed [fft_num_pkg::sample_width-1:0] a_re,
    input  logic signed [fft_num_pkg::sample_width-1:0] a_im,
    input  logic signed [fft_num_pkg::sample_width-1:0] b_re,
    input  logic signed [fft_num_pkg::sample_width-1:0] b_im,
    input  logic signed [twiddle_width-1:0]             w_re,
    input  logic signed [twiddle_width-1:0]             w_im,
    input  logic [tag_width-1:0]                        in_tag,
    output logic                                        out_valid,
    output logic signed [fft_num_pkg::sample_width-1:0] x_re,
    output logic signed [fft_num_pkg::sample_width-1:0] x_im,
    output logic signed [fft_num_pkg::sample_width-1:0] y_re,
    output logic signed [fft_num_pkg::sample_width-1:0] y_im,
    output logic [tag_width-1:0]                        out_tag
);
    import fft_num_pkg::*;

    localparam int prod_width = sample_width + twiddle_width;
    localparam int frac       = twiddle_width - 1;
    localparam logic signed [prod_width:0] round_half = 1 <<< (frac - 1);

    logic [2:0]                    valid_pipe;
    logic [tag_width-1:0]          tag_s1;
    logic [tag_width-1:0]          tag_s2;
    sample_t                       a_re_s1;
    sample_t                       a_im_s1;
    sample_t                       a_re_s2;
    sample_t                       a_im_s2;
    logic signed [prod_width-1:0]  p_rr;
    logic signed [prod_width-1:0]  p_ii;
    logic signed [prod_width-1:0]  p_ri;
    logic signed [prod_width-1:0]  p_ir;
    logic signed [prod_width:0]    rot_re_full;
    logic signed [prod_width:0]    rot_im_full;
    sample_t                       rot_re;
    sample_t                       rot_im;
    logic signed [sample_width+1:0] sum_re;
    logic signed [sample_width+1:0] sum_im;
    logic signed [sample_width+1:0] diff_re;
    logic signed [sample_width+1:0] diff_im;

    function automatic sample_t saturate(input logic signed [prod_width:0] value);
        if (value > prod_width'(2 ** (sample_width - 1) - 1)) begin
            return {1'b0, {(sample_width-1){1'b1}}};
        end
        if (value < -(prod_width'(2 ** (sample_width - 1)))) begin
            return {1'b1, {(sample_width-1){1'b0}}};
        end
        return value[sample_width-1:0];
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Rotation of b by w, then the half-scaled sum and difference
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign rot_re_full = (p_rr - p_ii + round_half) >>> frac;
    assign rot_im_full = (p_ri + p_ir + round_half) >>> frac;

    assign sum_re  = a_re_s2 + rot_re + 2'sd1;
    assign sum_im  = a_im_s2 + rot_im + 2'sd1;
    assign diff_re = a_re_s2 - rot_re + 2'sd1;
    assign diff_im = a_im_s2 - rot_im + 2'sd1;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[1:0], in_valid};
        end
    end

    assign out_valid = valid_pipe[2];

    always_ff @(posedge clk) begin
        p_rr    <= b_re * w_re;
        p_ii    <= b_im * w_im;
        p_ri    <= b_re * w_im;
        p_ir    <= b_im * w_re;
        a_re_s1 <= a_re;
        a_im_s1 <= a_im;
        tag_s1  <= in_tag;

        rot_re  <= saturate(rot_re_full);
        rot_im  <= saturate(rot_im_full);
        a_re_s2 <= a_re_s1;
        a_im_s2 <= a_im_s1;
        tag_s2  <= tag_s1;

        x_re    <= sum_re[sample_width:1];
        x_im    <= sum_im[sample_width:1];
        y_re    <= diff_re[sample_width:1];
        y_im    <= diff_im[sample_width:1];
        out_tag <= tag_s2;
    end

    assert property (@(posedge clk) disable iff (rst)
        in_valid |-> ##3 (out_valid && out_tag == $past(in_tag, 3)));

endmodule

//--- source/fft_engine.sv
`timescale 1ns/10ps

module fft_engine #(
    parameter int points = fft_num_pkg::fft_points,
    parameter int stages = fft_num_pkg::fft_stages
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  start,
    input  logic                                  load_we,
    input  logic [stages-1:0]                     load_addr,
    input  logic [2*fft_num_pkg::sample_width-1:0] load_data,
    input  logic [stages-1:0]                     rd_addr,
    output logic [2*fft_num_pkg::sample_width-1:0] rd_data,
    output logic                                  busy,
    output logic                                  done
);
    import fft_num_pkg::*;

    localparam int word_width = 2 * sample_width;
    localparam logic [stages-2:0] last_bf = (stages-1)'(points/2 - 1);
    // Cycles between the last issue of a stage and its last write-back
    localparam logic [1:0] drain_cycles = 2'd2;

    logic [word_width-1:0]          mem [points];
    logic [$clog2(stages)-1:0]      stage;
    logic [stages-2:0]              bf_cnt;
    logic                           issuing;
    logic [1:0]                     drain;
    logic [stages-1:0]              span;
    logic [stages-1:0]              pos;
    logic [stages-1:0]              top_addr;
    logic [stages-1:0]              bot_addr;
    logic [stages-2:0]              tw_index;
    logic                           bf_valid;
    logic [word_width-1:0]          bf_a;
    logic [word_width-1:0]          bf_b;
    logic signed [twiddle_width-1:0] bf_w_re;
    logic signed [twiddle_width-1:0] bf_w_im;
    logic [2*stages-1:0]            bf_tag;
    logic                           bf_out_valid;
    logic [2*stages-1:0]            bf_out_tag;
    sample_t                        bf_x_re;
    sample_t                        bf_x_im;
    sample_t                        bf_y_re;
    sample_t                        bf_y_im;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pair addresses and twiddle index for the current butterfly
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        span     = stages'(1) << stage;
        pos      = {1'b0, bf_cnt} & (span - stages'(1));
        top_addr = (({1'b0, bf_cnt} >> stage) << (int'(stage) + 1)) | pos;
        bot_addr = top_addr | span;
        tw_index = (stages-1)'(pos << (stages - 1 - int'(stage)));
    end

    assign bf_valid = issuing;
    assign bf_a     = mem[top_addr];
    assign bf_b     = mem[bot_addr];
    assign bf_tag   = {top_addr, bot_addr};

    twiddle_rom #(
        .points (points),
        .stages (stages)
    ) twiddle_rom_inst (
        .index (tw_index),
        .w_re  (bf_w_re),
        .w_im  (bf_w_im)
    );

    butterfly_unit #(
        .twiddle_width (twiddle_width),
        .tag_width     (2 * stages)
    ) butterfly_unit_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (bf_valid),
        .a_re      (bf_a[sample_width-1:0]),
        .a_im      (bf_a[word_width-1:sample_width]),
        .b_re      (bf_b[sample_width-1:0]),
        .b_im      (bf_b[word_width-1:sample_width]),
        .w_re      (bf_w_re),
        .w_im      (bf_w_im),
        .in_tag    (bf_tag),
        .out_valid (bf_out_valid),
        .x_re      (bf_x_re),
        .x_im      (bf_x_im),
        .y_re      (bf_y_re),
        .y_im      (bf_y_im),
        .out_tag   (bf_out_tag)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage sequencing: issue a full stage, drain, move on
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            done    <= 1'b0;
            issuing <= 1'b0;
            stage   <= '0;
            bf_cnt  <= '0;
            drain   <= '0;
        end else if (start && !busy) begin
            busy    <= 1'b1;
            done    <= 1'b0;
            issuing <= 1'b1;
            stage   <= '0;
            bf_cnt  <= '0;
        end else if (issuing) begin
            bf_cnt <= bf_cnt + 1'b1;
            if (bf_cnt == last_bf) begin
                issuing <= 1'b0;
                drain   <= drain_cycles;
            end
        end else if (busy) begin
            if (drain != 2'd0) begin
                drain <= drain - 2'd1;
            end else if (stage == stages - 1) begin
                busy <= 1'b0;
                done <= 1'b1;
            end else begin
                stage   <= stage + 1'b1;
                issuing <= 1'b1;
            end
        end
    end

    // Two write ports for the butterfly pair, one for the loader
    always_ff @(posedge clk) begin
        if (load_we && !busy) begin
            mem[load_addr] <= load_data;
        end
        if (bf_out_valid) begin
            mem[bf_out_tag[2*stages-1:stages]] <= {bf_x_im, bf_x_re};
            mem[bf_out_tag[stages-1:0]]        <= {bf_y_im, bf_y_re};
        end
        rd_data <= mem[rd_addr];
    end

    assert property (@(posedge clk) disable iff (rst) bf_out_valid |-> busy);
    assert property (@(posedge clk) disable iff (rst)
        (start && busy) |=> !(issuing && stage == '0 && bf_cnt == '0));

endmodule

//--- source/result_reader.sv
`timescale 1ns/10ps

module result_reader #(
    parameter int points = fft_num_pkg::fft_points,
    parameter int stages = fft_num_pkg::fft_stages
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   out_cyc,
    input  logic                                   out_stb,
    input  logic                                   out_we,
    input  logic [fft_bus_pkg::wb_addr_width-1:0]  out_adr,
    input  logic                                   busy,
    input  logic                                   done,
    input  logic [2*fft_num_pkg::sample_width-1:0] rd_data,
    output logic                                   out_ack,
    output logic [fft_bus_pkg::wb_data_width-1:0]  out_dat_r,
    output logic [stages-1:0]                      rd_addr
);
    import fft_bus_pkg::*;

    logic                     request;
    logic                     sel_bin;
    logic                     sel_status;
    logic [wb_data_width-1:0] status_word;

    assign request = out_cyc && out_stb && !out_ack;
    // The engine memory answers one clock later, in time for the acknowledge
    assign rd_addr = out_adr[stages-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            out_ack <= 1'b0;
        end else begin
            out_ack <= request;
        end
    end

    always_ff @(posedge clk) begin
        sel_bin     <= !out_we && (out_adr < points);
        sel_status  <= !out_we && (out_adr == reg_ctrl);
        status_word <= '0;
        status_word[status_busy_bit] <= busy;
        status_word[status_done_bit] <= done;
    end

    assign out_dat_r = sel_status ? status_word : (sel_bin ? rd_data : '0);

endmodule

//--- source/fft_top.sv
`timescale 1ns/10ps

module fft_top #(
    parameter int points = fft_num_pkg::fft_points,
    parameter int stages = fft_num_pkg::fft_stages
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  in_cyc,
    input  logic                                  in_stb,
    input  logic                                  in_we,
    input  logic [fft_bus_pkg::wb_addr_width-1:0] in_adr,
    input  logic [fft_bus_pkg::wb_data_width-1:0] in_dat_w,
    output logic                                  in_ack,
    output logic [fft_bus_pkg::wb_data_width-1:0] in_dat_r,
    input  logic                                  out_cyc,
    input  logic                                  out_stb,
    input  logic                                  out_we,
    input  logic [fft_bus_pkg::wb_addr_width-1:0] out_adr,
    output logic                                  out_ack,
    output logic [fft_bus_pkg::wb_data_width-1:0] out_dat_r
);
    import fft_num_pkg::*;

    logic                      start;
    logic                      busy;
    logic                      done;
    logic                      load_we;
    logic [stages-1:0]         load_addr;
    logic [stages-1:0]         rd_addr;
    logic [2*sample_width-1:0] load_data;
    logic [2*sample_width-1:0] rd_data;

    sample_loader #(
        .points (points),
        .stages (stages)
    ) sample_loader_inst (
        .clk       (clk),
        .rst       (rst),
        .in_cyc    (in_cyc),
        .in_stb    (in_stb),
        .in_we     (in_we),
        .in_adr    (in_adr),
        .in_dat_w  (in_dat_w),
        .busy      (busy),
        .in_ack    (in_ack),
        .in_dat_r  (in_dat_r),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .start     (start)
    );

    fft_engine #(
        .points (points),
        .stages (stages)
    ) fft_engine_inst (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .busy      (busy),
        .done      (done)
    );

    result_reader #(
        .points (points),
        .stages (stages)
    ) result_reader_inst (
        .clk       (clk),
        .rst       (rst),
        .out_cyc   (out_cyc),
        .out_stb   (out_stb),
        .out_we    (out_we),
        .out_adr   (out_adr),
        .busy      (busy),
        .done      (done),
        .rd_data   (rd_data),
        .out_ack   (out_ack),
        .out_dat_r (out_dat_r),
        .rd_addr   (rd_addr)
    );

endmodule

//--- bench/fft_tb.sv
`timescale 1ns/10ps

module fft_tb;
    import fft_bus_pkg::*;

    localparam int  points         = 16;
    localparam int  half_period    = 20;
    localparam int  drive_delay    = 2;
    localparam int  tolerance      = 4;
    localparam int  num_tests      = 8;
    localparam int  timeout_cycles = num_tests * ((16 + 17) * 4 + 200);
    localparam real pi             = 3.14159265358979;

    logic        clk = 1'b0;
    logic        rst;
    logic        in_cyc;
    logic        in_stb;
    logic        in_we;
    logic [4:0]  in_adr;
    logic [31:0] in_dat_w;
    logic        in_ack;
    logic [31:0] in_dat_r;
    logic        out_cyc;
    logic        out_stb;
    logic        out_we;
    logic [4:0]  out_adr;
    logic        out_ack;
    logic [31:0] out_dat_r;

    int errors = 0;
    int mark = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycle_count = 0;
    int x_re [points];
    int x_im [points];

    fft_top fft_top_inst (
        .clk       (clk),
        .rst       (rst),
        .in_cyc    (in_cyc),
        .in_stb    (in_stb),
        .in_we     (in_we),
        .in_adr    (in_adr),
        .in_dat_w  (in_dat_w),
        .in_ack    (in_ack),
        .in_dat_r  (in_dat_r),
        .out_cyc   (out_cyc),
        .out_stb   (out_stb),
        .out_we    (out_we),
        .out_adr   (out_adr),
        .out_ack   (out_ack),
        .out_dat_r (out_dat_r)
    );

    always #(half_period) clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            $display("Timeout: the run went past %0d cycles", timeout_cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Wishbone acknowledge rules on both ports
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assert property (@(posedge clk) disable iff (rst) $rose(in_cyc && in_stb) |=> in_ack)
        else begin
            errors++;
            $display("Input port missed the one-cycle acknowledge");
        end
    assert property (@(posedge clk) disable iff (rst) in_ack |=> !in_ack)
        else begin
            errors++;
            $display("Input port acknowledge lasted more than a cycle");
        end
    assert property (@(posedge clk) disable iff (rst) $rose(out_cyc && out_stb) |=> out_ack)
        else begin
            errors++;
            $display("Result port missed the one-cycle acknowledge");
        end
    assert property (@(posedge clk) disable iff (rst) out_ack |=> !out_ack)
        else begin
            errors++;
            $display("Result port acknowledge lasted more than a cycle");
        end

    // Tasks start and end 2 ns after a rising edge
    task automatic bus_write(input logic [4:0] adr, input logic [31:0] data);
        int wait_cycles;
        wait_cycles = 0;
        in_cyc = 1'b1;
        in_stb = 1'b1;
        in_we = 1'b1;
        in_adr = adr;
        in_dat_w = data;
        do begin
            @(posedge clk);
            #1;
            wait_cycles++;
        end while (!in_ack);
        assert (wait_cycles == 1) else begin
            errors++;
            $display("Input port acknowledged %0d cycles after the request", wait_cycles);
        end
        #1;
        in_cyc = 1'b0;
        in_stb = 1'b0;
        in_we = 1'b0;
        @(posedge clk);
        #(drive_delay);
    endtask

    task automatic input_port_read(input logic [4:0] adr, output logic [31:0] data);
        int wait_cycles;
        wait_cycles = 0;
        in_cyc = 1'b1;
        in_stb = 1'b1;
        in_we = 1'b0;
        in_adr = adr;
        do begin
            @(posedge clk);
            #1;
            wait_cycles++;
        end while (!in_ack);
        data = in_dat_r;
        assert (wait_cycles == 1) else begin
            errors++;
            $display("Input port acknowledged %0d cycles after the request", wait_cycles);
        end
        #1;
        in_cyc = 1'b0;
        in_stb = 1'b0;
        @(posedge clk);
        #(drive_delay);
    endtask

    task automatic bus_read(input logic [4:0] adr, output logic [31:0] data);
        int wait_cycles;
        wait_cycles = 0;
        out_cyc = 1'b1;
        out_stb = 1'b1;
        out_adr = adr;
        do begin
            @(posedge clk);
            #1;
            wait_cycles++;
        end while (!out_ack);
        data = out_dat_r;
        assert (wait_cycles == 1) else begin
            errors++;
            $display("Result port acknowledged %0d cycles after the request", wait_cycles);
        end
        #1;
        out_cyc = 1'b0;
        out_stb = 1'b0;
        @(posedge clk);
        #(drive_delay);
    endtask

    // Reads on the input port always return zero
    task automatic check_input_read(input logic [4:0] adr);
        logic [31:0] word;
        input_port_read(adr, word);
        assert (word == 32'h0) else begin
            errors++;
            $display("MISMATCH in_dat_r got %h expected %h", word, 32'h0);
        end
    endtask

    task automatic check_status(input logic busy_exp, input logic done_exp);
        logic [31:0] word;
        logic [31:0] expected;
        expected = '0;
        expected[status_busy_bit] = busy_exp;
        expected[status_done_bit] = done_exp;
        bus_read(reg_ctrl, word);
        assert (word == expected) else begin
            errors++;
            $display("MISMATCH out_dat_r status got %h expected %h", word, expected);
        end
    endtask

    task automatic wait_done();
        logic [31:0] word;
        do begin
            bus_read(reg_ctrl, word);
            assert (!(word[status_busy_bit] && word[status_done_bit])) else begin
                errors++;
                $display("Status word shows busy and done set together");
            end
        end while (!word[status_done_bit]);
    endtask

    task automatic compare_part(input string name, input int k, input int got, input real ref_val);
        int expected;
        expected = $rtoi($floor(ref_val + 0.5));
        assert (got >= ref_val - tolerance && got <= ref_val + tolerance) else begin
            errors++;
            $display("MISMATCH %s bin %0d got %h expected %h", name, k, 16'(got), 16'(expected));
        end
    endtask

    // Reference is the plain DFT divided by the point count
    task automatic check_bins();
        real ref_re;
        real ref_im;
        real angle;
        logic [31:0] word;
        for (int k = 0; k < points; k++) begin
            ref_re = 0.0;
            ref_im = 0.0;
            for (int n = 0; n < points; n++) begin
                angle = 2.0 * pi * k * n / points;
                ref_re += x_re[n] * $cos(angle) + x_im[n] * $sin(angle);
                ref_im += x_im[n] * $cos(angle) - x_re[n] * $sin(angle);
            end
            bus_read(5'(k), word);
            compare_part("out_dat_r[15:0]", k, int'($signed(word[15:0])), ref_re / points);
            compare_part("out_dat_r[31:16]", k, int'($signed(word[31:16])), ref_im / points);
        end
    endtask

    task automatic load_frame();
        for (int n = 0; n < points; n++) begin
            bus_write(5'(n), {x_im[n][15:0], x_re[n][15:0]});
        end
    endtask

    task automatic fill_frame(input int kind);
        for (int n = 0; n < points; n++) begin
            case (kind)
                0: x_re[n] = 'h0400;
                1: x_re[n] = (n == 0) ? 'h1000 : 0;
                default: x_re[n] = int'($urandom_range(32'h4000)) - 8192;
            endcase
            x_im[n] = (kind > 1) ? int'($urandom_range(32'h4000)) - 8192 : 0;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == mark) begin
            $display("PASS  %s", name);
        end else begin
            tests_failed++;
            $display("FAIL  %s", name);
        end
        mark = errors;
    endtask

    initial begin
        void'($urandom(32'hff67));
        rst = 1'b1;
        in_cyc = 1'b0;
        in_stb = 1'b0;
        in_we = 1'b0;
        in_adr = '0;
        in_dat_w = '0;
        out_cyc = 1'b0;
        out_stb = 1'b0;
        out_we = 1'b0;
        out_adr = '0;
        repeat (3) @(posedge clk);
        #(drive_delay);
        rst = 1'b0;

        check_status(1'b0, 1'b0);
        bus_write(5'd0, 32'h0);
        check_input_read(5'd0);
        check_input_read(reg_ctrl);
        finish_test("status after reset and acknowledge timing");

        fill_frame(0);
        load_frame();
        bus_write(reg_ctrl, 32'h1);
        wait_done();
        check_bins();
        finish_test("DC input");

        fill_frame(1);
        load_frame();
        bus_write(reg_ctrl, 32'h1);
        wait_done();
        check_status(1'b0, 1'b1);
        check_bins();
        finish_test("impulse input");

        for (int f = 0; f < 3; f++) begin
            fill_frame(2);
            load_frame();
            bus_write(reg_ctrl, 32'h1);
            wait_done();
            check_bins();
            finish_test($sformatf("random frame %0d", f));
        end

        // Writes and a second start land while the engine runs
        fill_frame(2);
        load_frame();
        bus_write(reg_ctrl, 32'h1);
        check_status(1'b1, 1'b0);
        for (int n = 0; n < 4; n++) begin
            bus_write(5'(n), 32'h7fff7fff);
        end
        bus_write(reg_ctrl, 32'h1);
        wait_done();
        check_bins();
        finish_test("writes and start while busy");

        repeat (3) check_status(1'b0, 1'b1);
        fill_frame(1);
        load_frame();
        check_status(1'b0, 1'b1);
        bus_write(reg_ctrl, 32'h1);
        check_status(1'b1, 1'b0);
        wait_done();
        check_bins();
        finish_test("done held until next start");

        $display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- compile.f
source/fft_num_pkg.sv
source/fft_bus_pkg.sv
source/sample_loader.sv
source/twiddle_rom.sv
source/butterfly_unit.sv
source/fft_engine.sv
source/result_reader.sv
source/fft_top.sv
bench/fft_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= fft_tb
SEED      ?= 1
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FLIST     ?= compile.f

SOURCES := $(wildcard source/*.sv) $(wildcard bench/*.sv)
VFLAGS  := --timing --assert -Wno-fatal --top-module $(TOP) -f $(FLIST)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FLIST)
	$(VERILATOR) --binary --x-assign unique --x-initial unique $(VFLAGS) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) +verilator+rand+reset+2 2>&1 | tee $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "All tests passed" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
